//--- all.f
+incdir+source
+incdir+tb
source/md_pkg.sv
source/md_mac_mult.sv
source/md_long_div.sv
source/md_unit.sv
tb/tb_md_unit.sv

//--- run.sh
#!/bin/sh
# Build the md_unit testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_md_unit -f all.f || exit 1
sim_out="$(./obj_dir/Vtb_md_unit)"
echo "$sim_out"
echo "$sim_out" | grep -q "No errors" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

//--- source/md_consts.svh
/*
 * RV32M multiply/divide constants
 * Operand widths, accumulator size and divider step count
 */

`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// Operand and result width
`define MD_XLEN 32
// Half width consumed by the MAC per step
`define MD_HALF 16
// Accumulator with room for sign and carry
`define MD_ACC_W 34
// Quotient bits produced by the long divider
`define MD_DIV_STEPS 32

`endif

//--- source/md_long_div.sv
/*
 * Radix-2 long divider for DIV and REM
 * Takes absolute values, runs compare-subtract steps and fixes the sign,
 * with an early exit on a zero divisor
 */

`timescale 1ns/1ps
`include "md_consts.svh"

module md_long_div (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_pkg::md_req_t     req_i,
  input  logic                ready_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  logic                 is_div;
  logic                 b_is_zero;
  logic                 div_sign_a;
  logic                 div_sign_b;
  logic                 div_change_sign;
  logic                 rem_change_sign;
  logic                 is_greater_equal;
  logic                 div_hold;
  logic                 div_en_int;

  // Own subtractor, a - b with the borrow in the top bit
  logic [`MD_XLEN:0]    adder_op_a;
  logic [`MD_XLEN:0]    adder_op_b;
  logic [`MD_XLEN:0]    adder_res;

  logic [`MD_XLEN-1:0]  one_shift;
  logic [`MD_XLEN-1:0]  next_remainder;
  logic [`MD_XLEN-1:0]  next_quotient;

  logic [`MD_XLEN-1:0]  numer_q;
  logic [`MD_XLEN-1:0]  numer_d;
  logic [`MD_XLEN-1:0]  denom_q;
  logic [`MD_XLEN-1:0]  denom_d;
  logic [`MD_XLEN-1:0]  quot_q;
  logic [`MD_XLEN-1:0]  quot_d;
  logic [`MD_XLEN-1:0]  rem_q;
  logic [`MD_XLEN-1:0]  rem_d;
  logic [4:0]           cnt_q;
  logic [4:0]           cnt_d;
  logic                 div_by_zero_q;
  logic                 div_by_zero_d;
  md_pkg::div_state_e   state_q;
  md_pkg::div_state_e   state_d;

  assign is_div     = (req_i.op == md_pkg::MD_OP_DIV);
  assign b_is_zero  = (req_i.op_b == '0);
  assign div_en_int = en_i & ~div_hold;

  assign div_sign_a      = req_i.op_a[`MD_XLEN-1] & req_i.signed_mode[0];
  assign div_sign_b      = req_i.op_b[`MD_XLEN-1] & req_i.signed_mode[1];
  assign div_change_sign = (div_sign_a ^ div_sign_b) & ~div_by_zero_q;
  // Remainder takes the sign of the dividend
  assign rem_change_sign = div_sign_a;

  assign adder_res = adder_op_a - adder_op_b;

  // Both magnitudes are unsigned here, no borrow means remainder >= divisor
  assign is_greater_equal = ~adder_res[`MD_XLEN];

  assign one_shift      = `MD_XLEN'(1) << cnt_q;
  assign next_remainder = is_greater_equal ? adder_res[`MD_XLEN-1:0] : rem_q;
  assign next_quotient  = is_greater_equal ? (quot_q | one_shift) : quot_q;

  always_comb begin
    cnt_d         = cnt_q - 5'd1;
    numer_d       = numer_q;
    denom_d       = denom_q;
    quot_d        = quot_q;
    rem_d         = rem_q;
    div_by_zero_d = div_by_zero_q;
    state_d       = state_q;
    adder_op_a    = '0;
    adder_op_b    = {1'b0, req_i.op_b};
    valid_o       = 1'b0;
    div_hold      = 1'b0;

    unique case (state_q)
      md_pkg::DIV_IDLE: begin
        // Preload the RISC-V divide-by-zero result
        rem_d         = is_div ? '1 : req_i.op_a;
        div_by_zero_d = b_is_zero;
        state_d       = b_is_zero ? md_pkg::DIV_FINISH : md_pkg::DIV_ABS_A;
        cnt_d         = 5'(`MD_DIV_STEPS - 1);
      end

      md_pkg::DIV_ABS_A: begin
        // |a| = 0 - a
        adder_op_b = {1'b0, req_i.op_a};
        quot_d     = '0;
        numer_d    = div_sign_a ? adder_res[`MD_XLEN-1:0] : req_i.op_a;
        cnt_d      = 5'(`MD_DIV_STEPS - 1);
        state_d    = md_pkg::DIV_ABS_B;
      end

      md_pkg::DIV_ABS_B: begin
        // |b| = 0 - b, first numerator bit enters the remainder
        denom_d = div_sign_b ? adder_res[`MD_XLEN-1:0] : req_i.op_b;
        rem_d   = {{(`MD_XLEN-1){1'b0}}, numer_q[`MD_XLEN-1]};
        cnt_d   = 5'(`MD_DIV_STEPS - 1);
        state_d = md_pkg::DIV_COMP;
      end

      md_pkg::DIV_COMP: begin
        adder_op_a = {1'b0, rem_q};
        adder_op_b = {1'b0, denom_q};
        // Next remainder is below the divisor, so its top bit is always clear
        rem_d      = {next_remainder[`MD_XLEN-2:0], numer_q[cnt_d]};
        quot_d     = next_quotient;
        state_d    = (cnt_q == 5'd1) ? md_pkg::DIV_LAST : md_pkg::DIV_COMP;
      end

      md_pkg::DIV_LAST: begin
        // Final quotient bit, keep only the value the opcode asks for
        adder_op_a = {1'b0, rem_q};
        adder_op_b = {1'b0, denom_q};
        rem_d      = is_div ? next_quotient : next_remainder;
        state_d    = md_pkg::DIV_CHANGE_SIGN;
      end

      md_pkg::DIV_CHANGE_SIGN: begin
        adder_op_b = {1'b0, rem_q};
        if (is_div) begin
          rem_d = div_change_sign ? adder_res[`MD_XLEN-1:0] : rem_q;
        end else begin
          rem_d = rem_change_sign ? adder_res[`MD_XLEN-1:0] : rem_q;
        end
        state_d = md_pkg::DIV_FINISH;
      end

      md_pkg::DIV_FINISH: begin
        // Result waits here until the consumer takes it
        valid_o  = 1'b1;
        div_hold = ~ready_i;
        state_d  = md_pkg::DIV_IDLE;
      end

      default: begin
        state_d = md_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= md_pkg::DIV_IDLE;
      cnt_q         <= '0;
      numer_q       <= '0;
      denom_q       <= '0;
      quot_q        <= '0;
      rem_q         <= '0;
      div_by_zero_q <= 1'b0;
    end else if (div_en_int) begin
      state_q       <= state_d;
      cnt_q         <= cnt_d;
      numer_q       <= numer_d;
      denom_q       <= denom_d;
      quot_q        <= quot_d;
      rem_q         <= rem_d;
      div_by_zero_q <= div_by_zero_d;
    end
  end

  assign result_o = rem_q;

  a_div_state_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {md_pkg::DIV_IDLE, md_pkg::DIV_ABS_A, md_pkg::DIV_ABS_B,
                    md_pkg::DIV_COMP, md_pkg::DIV_LAST, md_pkg::DIV_CHANGE_SIGN,
                    md_pkg::DIV_FINISH}
  ) else $error("divider state outside encoding");

endmodule

//--- source/md_mac_mult.sv
/*
 * Iterative 16x16 MAC multiplier
 * Walks al*bl, al*bh, ah*bl and ah*bh through one 17x17 signed multiplier,
 * MUL finishes in three cycles and MULH in four
 */

`timescale 1ns/1ps
`include "md_consts.svh"

module md_mac_mult (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_pkg::md_req_t     req_i,
  input  logic                ready_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  logic [`MD_HALF-1:0]  mult_op_a;
  logic [`MD_HALF-1:0]  mult_op_b;
  logic                 sign_a;
  logic                 sign_b;
  logic                 signed_mult;
  logic                 is_mul;
  logic                 mult_hold;
  logic                 mult_en_int;
  logic [`MD_ACC_W-1:0] accum;
  logic [`MD_ACC_W-1:0] accum_q;
  logic [`MD_ACC_W-1:0] mac_res;
  logic [`MD_ACC_W-1:0] mac_res_d;
  md_pkg::mult_state_e  state_q;
  md_pkg::mult_state_e  state_d;

  assign is_mul      = (req_i.op == md_pkg::MD_OP_MUL);
  assign signed_mult = |req_i.signed_mode;
  assign mult_en_int = en_i & ~mult_hold;

  // Single signed 17x17 product plus addend, result fits the accumulator exactly
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                   + $signed(accum);

  always_comb begin
    mult_op_a = req_i.op_a[`MD_HALF-1:0];
    mult_op_b = req_i.op_b[`MD_HALF-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = accum_q;
    mac_res_d = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;
    mult_hold = 1'b0;

    unique case (state_q)
      md_pkg::ALBL: begin
        // al*bl, always unsigned
        accum   = '0;
        state_d = md_pkg::ALBH;
      end

      md_pkg::ALBH: begin
        // al*bh, shifted down by the low half of al*bl
        mult_op_b = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];
        accum     = {{(`MD_ACC_W-`MD_HALF){1'b0}}, accum_q[`MD_XLEN-1:`MD_HALF]};
        if (is_mul) begin
          // Keep the finished low half of al*bl below the new sum
          mac_res_d = {{(`MD_ACC_W-`MD_XLEN){1'b0}}, mac_res[`MD_HALF-1:0],
                       accum_q[`MD_HALF-1:0]};
        end
        state_d = md_pkg::AHBL;
      end

      md_pkg::AHBL: begin
        // ah*bl
        mult_op_a = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
        if (is_mul) begin
          accum     = {{(`MD_ACC_W-`MD_HALF){1'b0}}, accum_q[`MD_XLEN-1:`MD_HALF]};
          mac_res_d = {{(`MD_ACC_W-`MD_XLEN){1'b0}}, mac_res[`MD_HALF-1:0],
                       accum_q[`MD_HALF-1:0]};
          valid_o   = 1'b1;
          // Stays here while the consumer stalls
          mult_hold = ~ready_i;
          state_d   = md_pkg::ALBL;
        end else begin
          state_d = md_pkg::AHBH;
        end
      end

      md_pkg::AHBH: begin
        // ah*bh, only reached for MULH
        mult_op_a = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        mult_op_b = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
        sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];
        // Partial sum is signed unless both operands are unsigned
        accum     = {{`MD_HALF{signed_mult & accum_q[`MD_ACC_W-1]}},
                     accum_q[`MD_ACC_W-1:`MD_HALF]};
        valid_o   = 1'b1;
        mult_hold = ~ready_i;
        state_d   = md_pkg::ALBL;
      end

      default: begin
        state_d = md_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::ALBL;
      accum_q <= '0;
    end else if (mult_en_int) begin
      state_q <= state_d;
      accum_q <= mac_res_d;
    end
  end

  // Upper half of the MULH result or the full MUL word
  assign result_o = mac_res_d[`MD_XLEN-1:0];

  a_mult_state_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q)
  ) else $error("multiplier state is unknown");

endmodule

//--- source/md_pkg.sv
/*
 * RV32M multiply/divide package
 * Request type, opcode and engine state encodings
 */

`include "md_consts.svh"

package md_pkg;

  // Requested operation
  typedef enum logic [1:0] {
    MD_OP_MUL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Bit 0 marks op_a signed, bit 1 marks op_b signed
  typedef struct packed {
    md_op_e              op;
    logic [1:0]          signed_mode;
    logic [`MD_XLEN-1:0] op_a;
    logic [`MD_XLEN-1:0] op_b;
  } md_req_t;

  // Partial product currently being accumulated
  typedef enum logic [1:0] {ALBL, ALBH, AHBL, AHBH} mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

endpackage

//--- source/md_unit.sv
/*
 * RV32M multiply/divide unit
 * Routes each request to the MAC multiplier or the long divider
 */

`timescale 1ns/1ps
`include "md_consts.svh"

module md_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                en_i,
  input  md_pkg::md_req_t     req_i,
  input  logic                ready_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o
);

  logic                mult_sel;
  logic                div_sel;
  logic                mult_valid;
  logic                div_valid;
  logic [`MD_XLEN-1:0] mult_result;
  logic [`MD_XLEN-1:0] div_result;

  // Opcode class picks the engine
  assign mult_sel = req_i.op inside {md_pkg::MD_OP_MUL, md_pkg::MD_OP_MULH};
  assign div_sel  = req_i.op inside {md_pkg::MD_OP_DIV, md_pkg::MD_OP_REM};

  md_mac_mult i_md_mac_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i & mult_sel),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (mult_result),
    .valid_o  (mult_valid)
  );

  md_long_div i_md_long_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i & div_sel),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (div_result),
    .valid_o  (div_valid)
  );

  assign valid_o  = mult_valid | div_valid;
  assign result_o = div_sel ? div_result : mult_result;

  // At most one engine ever presents a result
  a_single_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(mult_valid && div_valid)
  ) else $error("both engines valid");

  // A stalled result stays put until it is taken
  a_hold_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o)
  ) else $error("result changed under back-pressure");

endmodule

//--- tb/md_tests.svh
/*
 * Directed tests for the RV32M multiply/divide unit
 * Each task drives requests and checks results and timing against the model
 */

  // Multiplier corners, including the half-word boundary
  logic [`MD_XLEN-1:0] corner_vals [6] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                           32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_FFFF};

  // Divider corner pairs, dividend and divisor
  logic [`MD_XLEN-1:0] div_a_vals [7] = '{32'd7, 32'hFFFF_FFF9, 32'h8000_0000,
                                          32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'd1, 32'd0};
  logic [`MD_XLEN-1:0] div_b_vals [7] = '{32'd2, 32'd2, 32'd3, 32'hFFFF_FFFF,
                                          32'h8000_0000, 32'hFFFF_FFFE, 32'd5};

  task automatic mult_corner_cases();
    int i;
    int j;
    int m;
    for (m = 0; m < 4; m++) begin
      for (i = 0; i < 6; i++) begin
        for (j = 0; j < 6; j++) begin
          run_single_op(md_pkg::MD_OP_MUL, m[1:0], corner_vals[i], corner_vals[j]);
          run_single_op(md_pkg::MD_OP_MULH, m[1:0], corner_vals[i], corner_vals[j]);
        end
      end
    end
  endtask

  task automatic mult_random_pairs();
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    int                  i;
    int                  m;
    for (i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      for (m = 0; m < 4; m++) begin
        run_single_op(md_pkg::MD_OP_MUL, m[1:0], a, b);
        run_single_op(md_pkg::MD_OP_MULH, m[1:0], a, b);
      end
    end
  endtask

  task automatic div_corner_cases();
    logic [1:0] mode;
    int         i;
    int         m;
    for (m = 0; m < 2; m++) begin
      mode = (m == 0) ? 2'b00 : 2'b11;
      for (i = 0; i < 7; i++) begin
        run_single_op(md_pkg::MD_OP_DIV, mode, div_a_vals[i], div_b_vals[i]);
        run_single_op(md_pkg::MD_OP_REM, mode, div_a_vals[i], div_b_vals[i]);
      end
    end
  endtask

  task automatic div_random_pairs();
    logic [`MD_XLEN-1:0] a;
    logic [`MD_XLEN-1:0] b;
    logic [`MD_XLEN-1:0] rnd;
    int                  i;
    for (i = 0; i < 6; i++) begin
      a   = $random(seed);
      rnd = $random(seed);
      // Shrinking divisors give quotients of many sizes
      b   = rnd >> (5 * i);
      run_single_op(md_pkg::MD_OP_DIV, 2'b00, a, b);
      run_single_op(md_pkg::MD_OP_REM, 2'b00, a, b);
      run_single_op(md_pkg::MD_OP_DIV, 2'b11, a, b);
      run_single_op(md_pkg::MD_OP_REM, 2'b11, a, b);
    end
  endtask

  task automatic div_zero_and_overflow();
    logic [`MD_XLEN-1:0] dividend [3];
    int                  i;
    dividend = '{32'd123, 32'h8000_0000, 32'hFFFF_FFFF};
    for (i = 0; i < 3; i++) begin
      run_single_op(md_pkg::MD_OP_DIV, 2'b00, dividend[i], 32'd0);
      run_single_op(md_pkg::MD_OP_REM, 2'b00, dividend[i], 32'd0);
      run_single_op(md_pkg::MD_OP_DIV, 2'b11, dividend[i], 32'd0);
      run_single_op(md_pkg::MD_OP_REM, 2'b11, dividend[i], 32'd0);
    end
    run_single_op(md_pkg::MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF);
    run_single_op(md_pkg::MD_OP_REM, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF);
  endtask

  // Holds ready_i low for five cycles once the result is up
  task automatic hold_under_stall(input md_pkg::md_op_e op, input logic [1:0] mode,
                                  input logic [`MD_XLEN-1:0] a,
                                  input logic [`MD_XLEN-1:0] b);
    md_pkg::md_req_t     r;
    logic [`MD_XLEN-1:0] held;
    int                  latency;
    int                  k;
    r = make_request(op, mode, a, b);
    @(negedge clk_i);
    ready_i = 1'b0;
    req_i   = r;
    en_i    = 1'b1;
    wait_for_valid(latency);
    check_value("result_o", result_o, expected_result(r));
    check_value("valid_o latency", latency, expected_latency(r));
    held = result_o;
    for (k = 0; k < 5; k++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("valid_o", 32'(valid_o), 32'd1);
      check_value("result_o", result_o, held);
    end
    ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    en_i = 1'b0;
    // Taken result leaves the engine idle
    check_value("valid_o", 32'(valid_o), '0);
  endtask

  task automatic stall_during_results();
    hold_under_stall(md_pkg::MD_OP_MULH, 2'b11, 32'hC0DE_1234, 32'h8765_ABCD);
    hold_under_stall(md_pkg::MD_OP_DIV, 2'b11, 32'hF000_0123, 32'h0000_0456);
  endtask

  task automatic back_to_back_ops();
    md_pkg::md_req_t chain [4];
    int              latency;
    int              k;
    chain[0] = make_request(md_pkg::MD_OP_MUL, 2'b11, 32'h1234_5678, 32'h9ABC_DEF0);
    chain[1] = make_request(md_pkg::MD_OP_DIV, 2'b11, 32'hFEDC_BA98, 32'h0000_1234);
    chain[2] = make_request(md_pkg::MD_OP_MULH, 2'b01, 32'h8765_4321, 32'hFFFF_0001);
    chain[3] = make_request(md_pkg::MD_OP_REM, 2'b00, 32'hDEAD_BEEF, 32'h0000_00FF);
    @(negedge clk_i);
    en_i = 1'b1;
    for (k = 0; k < 4; k++) begin
      // Next request lands in the half cycle after the previous acceptance
      req_i = chain[k];
      wait_for_valid(latency);
      check_value("result_o", result_o, expected_result(chain[k]));
      check_value("valid_o latency", latency, expected_latency(chain[k]));
      @(posedge clk_i);
      @(negedge clk_i);
    end
    en_i = 1'b0;
  endtask

//--- tb/tb_md_unit.sv
/*
 * Testbench for the RV32M multiply/divide unit
 * Clock, reset, reference model, check helpers, timeout and summary
 */

`timescale 1ns/1ps
`include "md_consts.svh"

module tb_md_unit;

  // The directed tests take about 4300 cycles, the rest is margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic                clk_i;
  logic                rst_ni;
  logic                en_i;
  md_pkg::md_req_t     req_i;
  logic                ready_i;
  logic [`MD_XLEN-1:0] result_o;
  logic                valid_o;

  int     error_count;
  int     check_count;
  int     cycle_count;
  integer seed;

  md_unit i_md_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a test never saw valid_o", cycle_count);
      $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("Errors found");
      $finish;
    end
  end

  function automatic md_pkg::md_req_t make_request(input md_pkg::md_op_e op,
                                                   input logic [1:0] mode,
                                                   input logic [`MD_XLEN-1:0] a,
                                                   input logic [`MD_XLEN-1:0] b);
    md_pkg::md_req_t r;
    r.op          = op;
    r.signed_mode = mode;
    r.op_a        = a;
    r.op_b        = b;
    return r;
  endfunction

  // RISC-V M results from 64-bit products and the divide corner rules
  function automatic logic [`MD_XLEN-1:0] expected_result(input md_pkg::md_req_t r);
    logic [63:0]         a64;
    logic [63:0]         b64;
    logic [63:0]         prod;
    logic                is_signed;
    logic [`MD_XLEN-1:0] quot;
    logic [`MD_XLEN-1:0] rem;
    logic [`MD_XLEN-1:0] res;
    a64       = r.signed_mode[0] ? {{32{r.op_a[31]}}, r.op_a} : {32'h0, r.op_a};
    b64       = r.signed_mode[1] ? {{32{r.op_b[31]}}, r.op_b} : {32'h0, r.op_b};
    prod      = a64 * b64;
    is_signed = &r.signed_mode;
    if (r.op_b == '0) begin
      quot = '1;
      rem  = r.op_a;
    end else if (is_signed && r.op_a == 32'h8000_0000 && r.op_b == 32'hFFFF_FFFF) begin
      // Signed overflow
      quot = 32'h8000_0000;
      rem  = '0;
    end else if (is_signed) begin
      quot = $signed(r.op_a) / $signed(r.op_b);
      rem  = $signed(r.op_a) % $signed(r.op_b);
    end else begin
      quot = r.op_a / r.op_b;
      rem  = r.op_a % r.op_b;
    end
    case (r.op)
      md_pkg::MD_OP_MUL:  res = prod[31:0];
      md_pkg::MD_OP_MULH: res = prod[63:32];
      md_pkg::MD_OP_DIV:  res = quot;
      default:            res = rem;
    endcase
    return res;
  endfunction

  // Rising edge at which valid_o is first seen, counting the start edge as 0
  function automatic int expected_latency(input md_pkg::md_req_t r);
    int edges;
    case (r.op)
      md_pkg::MD_OP_MUL:  edges = 2;
      md_pkg::MD_OP_MULH: edges = 3;
      // Idle, two abs steps, the compare steps, sign fix, then finish
      default:            edges = (r.op_b == '0) ? 1 : `MD_DIV_STEPS + 4;
    endcase
    return edges;
  endfunction

  task automatic check_value(input string name, input logic [`MD_XLEN-1:0] got,
                             input logic [`MD_XLEN-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Returns on the falling edge where valid_o is high
  task automatic wait_for_valid(output int edges);
    edges = 0;
    do begin
      @(posedge clk_i);
      @(negedge clk_i);
      edges++;
    end while (valid_o !== 1'b1);
  endtask

  task automatic run_single_op(input md_pkg::md_op_e op, input logic [1:0] mode,
                               input logic [`MD_XLEN-1:0] a,
                               input logic [`MD_XLEN-1:0] b);
    md_pkg::md_req_t r;
    int              latency;
    r = make_request(op, mode, a, b);
    @(negedge clk_i);
    req_i = r;
    en_i  = 1'b1;
    wait_for_valid(latency);
    check_value("result_o", result_o, expected_result(r));
    check_value("valid_o latency", latency, expected_latency(r));
    // Ready is high, so the next edge takes the result
    @(posedge clk_i);
    @(negedge clk_i);
    en_i = 1'b0;
  endtask

  `include "md_tests.svh"

  initial begin
    $timeformat(-9, 0, " ns", 0);
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    seed        = 32'h292e_66af;
    rst_ni      = 1'b0;
    en_i        = 1'b0;
    ready_i     = 1'b1;
    // REM request puts the divider's remainder register on result_o
    req_i       = make_request(md_pkg::MD_OP_REM, 2'b00, '0, '0);
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Idle unit straight out of reset
    check_value("valid_o", 32'(valid_o), '0);
    check_value("result_o", result_o, '0);

    mult_corner_cases();
    mult_random_pairs();
    div_corner_cases();
    div_random_pairs();
    div_zero_and_overflow();
    stall_during_results();
    back_to_back_ops();

    @(negedge clk_i);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
